/* logic/vidin_config.svh */
`ifndef VIDIN_CONFIG_SVH
`define VIDIN_CONFIG_SVH

// Width of one bus word, four of them ride on each write
`define VIDIN_WORD_W 16

// Pixel address carried by the commit slot
`define VIDIN_ADDR_W 19

`define VIDIN_SLOT_W 3

// Column field inside the pixel address, so the row starts at this bit
`define VIDIN_COL_BITS 9

`endif

/* logic/vidin_bus_pkg.sv */
`default_nettype none

`include "vidin_config.svh"

package vidin_bus_pkg;

   // Slot codes as they arrive on adr
   // Slots 2 to 7 stage the quads in pyramid order, left before right
   typedef enum logic [`VIDIN_SLOT_W-1:0] {
      slot_nop      = 0,
      slot_commit   = 1,
      slot_s1_left  = 2,
      slot_s1_right = 3,
      slot_s2_left  = 4,
      slot_s2_right = 5,
      slot_s4_left  = 6,
      slot_s4_right = 7
   } slot_e;

   typedef logic [`VIDIN_WORD_W-1:0] bus_word_t;

endpackage

`default_nettype wire

/* logic/vidin_frame_pkg.sv */
`default_nettype none

`include "vidin_config.svh"

package vidin_frame_pkg;

   // Row in the upper bits, column in the low VIDIN_COL_BITS
   typedef logic [`VIDIN_ADDR_W-1:0] pix_addr_t;

   // Components packed rp, ip, rn, in from the top down
   typedef logic [4*`VIDIN_WORD_W-1:0] quad_t;

   // One new-data strobe per quad, bit 0 is scale 1 left
   // Bits run in slot order: s1 l/r, s2 l/r, s4 l/r
   typedef logic [5:0] strobe_t;

endpackage

`default_nettype wire

/* logic/vidin_wb_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vidin_config.svh"

module vidin_wb_port (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          cyc,
   input  wire logic                          stb,
   input  wire logic                          we,
   input  wire logic [`VIDIN_SLOT_W-1:0]      adr,
   input  wire logic [4*`VIDIN_WORD_W-1:0]    dat_w,
   output logic                               ack,
   output logic                               slot_valid,
   output vidin_bus_pkg::slot_e               slot,
   output vidin_bus_pkg::bus_word_t           word0,
   output vidin_bus_pkg::bus_word_t           word1,
   output vidin_bus_pkg::bus_word_t           word2,
   output vidin_bus_pkg::bus_word_t           word3
);

   import vidin_bus_pkg::*;

   logic req;
   logic accept;
   logic held;

   assign req = cyc && stb;

   // A request is taken once, then held off until the master drops stb
   assign accept = req && !held;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack        <= 1'b0;
         slot_valid <= 1'b0;
         held       <= 1'b0;
      end
      else
      begin
         ack        <= accept;
         slot_valid <= accept && we;
         held       <= req;
      end
   end

   // Slot code and words only matter while slot_valid is high
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         slot  <= slot_e'(adr);
         word0 <= dat_w[`VIDIN_WORD_W-1:0];
         word1 <= dat_w[2*`VIDIN_WORD_W-1:`VIDIN_WORD_W];
         word2 <= dat_w[3*`VIDIN_WORD_W-1:2*`VIDIN_WORD_W];
         word3 <= dat_w[4*`VIDIN_WORD_W-1:3*`VIDIN_WORD_W];
      end
   end

   // Each request gets one ack pulse and never a stretched one
   ack_single_cycle: assert property (
      @(posedge clk) disable iff (rst) ack |=> !ack
   );

endmodule

`default_nettype wire

/* logic/vidin_frame_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vidin_config.svh"

module vidin_frame_stage (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      slot_valid,
   input  wire vidin_bus_pkg::slot_e      slot,
   input  wire vidin_bus_pkg::bus_word_t  word0,
   input  wire vidin_bus_pkg::bus_word_t  word1,
   input  wire vidin_bus_pkg::bus_word_t  word2,
   input  wire vidin_bus_pkg::bus_word_t  word3,
   output vidin_frame_pkg::quad_t         q_s1_left,
   output vidin_frame_pkg::quad_t         q_s1_right,
   output vidin_frame_pkg::quad_t         q_s2_left,
   output vidin_frame_pkg::quad_t         q_s2_right,
   output vidin_frame_pkg::quad_t         q_s4_left,
   output vidin_frame_pkg::quad_t         q_s4_right
);

   import vidin_bus_pkg::*;
   import vidin_frame_pkg::*;

   quad_t quad_in;

   // Word 0 is rp and lands in the top of the quad
   assign quad_in = {word0, word1, word2, word3};

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         q_s1_left  <= '0;
         q_s1_right <= '0;
         q_s2_left  <= '0;
         q_s2_right <= '0;
         q_s4_left  <= '0;
         q_s4_right <= '0;
      end
      else if (slot_valid)
      begin
         case (slot)
            slot_s1_left:
               q_s1_left <= quad_in;
            slot_s1_right:
               q_s1_right <= quad_in;
            slot_s2_left:
               q_s2_left <= quad_in;
            slot_s2_right:
               q_s2_right <= quad_in;
            slot_s4_left:
               q_s4_left <= quad_in;
            slot_s4_right:
               q_s4_right <= quad_in;
            // Commit and no-op leave the staged frame alone
            default:
            begin
            end
         endcase
      end
   end

   // The port must hand over a clean slot code with every event
   slot_known: assert property (
      @(posedge clk) disable iff (rst) slot_valid |-> !$isunknown(slot)
   );

endmodule

`default_nettype wire

/* logic/vidin_frame_publish.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vidin_config.svh"

module vidin_frame_publish (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      slot_valid,
   input  wire vidin_bus_pkg::slot_e      slot,
   input  wire vidin_bus_pkg::bus_word_t  word0,
   input  wire vidin_bus_pkg::bus_word_t  word1,
   input  wire vidin_frame_pkg::quad_t    q_s1_left,
   input  wire vidin_frame_pkg::quad_t    q_s1_right,
   input  wire vidin_frame_pkg::quad_t    q_s2_left,
   input  wire vidin_frame_pkg::quad_t    q_s2_right,
   input  wire vidin_frame_pkg::quad_t    q_s4_left,
   input  wire vidin_frame_pkg::quad_t    q_s4_right,
   output vidin_frame_pkg::pix_addr_t     pix_addr,
   output logic                           comp_switch,
   output vidin_frame_pkg::strobe_t       new_data,
   output vidin_frame_pkg::quad_t         out_s1_left,
   output vidin_frame_pkg::quad_t         out_s1_right,
   output vidin_frame_pkg::quad_t         out_s2_left,
   output vidin_frame_pkg::quad_t         out_s2_right,
   output vidin_frame_pkg::quad_t         out_s4_left,
   output vidin_frame_pkg::quad_t         out_s4_right
);

   import vidin_bus_pkg::*;
   import vidin_frame_pkg::*;

   // Address bits that spill over from word0 into the top of word1
   localparam int HI_BITS = `VIDIN_ADDR_W - `VIDIN_WORD_W;
   localparam int SW_BIT  = `VIDIN_WORD_W - 1 - HI_BITS;

   logic      commit;
   pix_addr_t addr_next;
   logic      keep_s2;
   logic      keep_s4;
   strobe_t   strobe_next;

   assign commit    = slot_valid && (slot == slot_commit);
   assign addr_next = {word1[`VIDIN_WORD_W-1 -: HI_BITS], word0};

   // Scale 2 takes every second column and row, scale 4 every fourth
   assign keep_s2 = !addr_next[0] && !addr_next[`VIDIN_COL_BITS];
   assign keep_s4 = keep_s2 && !addr_next[1] && !addr_next[`VIDIN_COL_BITS+1];

   assign strobe_next = {keep_s4, keep_s4, keep_s2, keep_s2, 2'b11};

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pix_addr     <= '0;
         comp_switch  <= 1'b0;
         new_data     <= '0;
         out_s1_left  <= '0;
         out_s1_right <= '0;
         out_s2_left  <= '0;
         out_s2_right <= '0;
         out_s4_left  <= '0;
         out_s4_right <= '0;
      end
      else if (commit)
      begin
         pix_addr     <= addr_next;
         comp_switch  <= word1[SW_BIT];
         new_data     <= strobe_next;
         out_s1_left  <= q_s1_left;
         out_s1_right <= q_s1_right;
         out_s2_left  <= q_s2_left;
         out_s2_right <= q_s2_right;
         out_s4_left  <= q_s4_left;
         out_s4_right <= q_s4_right;
      end
      else
      begin
         // Outputs hold between commits, strobes are single pulses
         new_data <= '0;
      end
   end

   // The pyramid never announces a coarse sample without the finer ones
   strobe_nesting: assert property (
      @(posedge clk) disable iff (rst)
         ((new_data[5:4] & ~new_data[3:2]) == 2'b00) &&
         ((new_data[3:2] & ~new_data[1:0]) == 2'b00)
   );

endmodule

`default_nettype wire

/* logic/vidin_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vidin_config.svh"

module vidin_rx_top (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          cyc,
   input  wire logic                          stb,
   input  wire logic                          we,
   input  wire logic [`VIDIN_SLOT_W-1:0]      adr,
   input  wire logic [4*`VIDIN_WORD_W-1:0]    dat_w,
   output logic                               ack,
   output vidin_frame_pkg::pix_addr_t         pix_addr,
   output logic                               comp_switch,
   output vidin_frame_pkg::strobe_t           new_data,
   output vidin_frame_pkg::quad_t             out_s1_left,
   output vidin_frame_pkg::quad_t             out_s1_right,
   output vidin_frame_pkg::quad_t             out_s2_left,
   output vidin_frame_pkg::quad_t             out_s2_right,
   output vidin_frame_pkg::quad_t             out_s4_left,
   output vidin_frame_pkg::quad_t             out_s4_right
);

   import vidin_bus_pkg::*;
   import vidin_frame_pkg::*;

   logic      slot_valid;
   slot_e     slot;
   bus_word_t word0;
   bus_word_t word1;
   bus_word_t word2;
   bus_word_t word3;

   // Staged frame, held until the next commit copies it out
   quad_t q_s1_left;
   quad_t q_s1_right;
   quad_t q_s2_left;
   quad_t q_s2_right;
   quad_t q_s4_left;
   quad_t q_s4_right;

   vidin_wb_port u_wb_port (
      .clk        (clk),
      .rst        (rst),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .ack        (ack),
      .slot_valid (slot_valid),
      .slot       (slot),
      .word0      (word0),
      .word1      (word1),
      .word2      (word2),
      .word3      (word3)
   );

   vidin_frame_stage u_frame_stage (
      .clk        (clk),
      .rst        (rst),
      .slot_valid (slot_valid),
      .slot       (slot),
      .word0      (word0),
      .word1      (word1),
      .word2      (word2),
      .word3      (word3),
      .q_s1_left  (q_s1_left),
      .q_s1_right (q_s1_right),
      .q_s2_left  (q_s2_left),
      .q_s2_right (q_s2_right),
      .q_s4_left  (q_s4_left),
      .q_s4_right (q_s4_right)
   );

   // Only the commit's first two words reach the publisher
   vidin_frame_publish u_frame_publish (
      .clk          (clk),
      .rst          (rst),
      .slot_valid   (slot_valid),
      .slot         (slot),
      .word0        (word0),
      .word1        (word1),
      .q_s1_left    (q_s1_left),
      .q_s1_right   (q_s1_right),
      .q_s2_left    (q_s2_left),
      .q_s2_right   (q_s2_right),
      .q_s4_left    (q_s4_left),
      .q_s4_right   (q_s4_right),
      .pix_addr     (pix_addr),
      .comp_switch  (comp_switch),
      .new_data     (new_data),
      .out_s1_left  (out_s1_left),
      .out_s1_right (out_s1_right),
      .out_s2_left  (out_s2_left),
      .out_s2_right (out_s2_right),
      .out_s4_left  (out_s4_left),
      .out_s4_right (out_s4_right)
   );

endmodule

`default_nettype wire

/* testbench/vidin_rx_ref.svh */
`ifndef VIDIN_RX_REF_SVH
`define VIDIN_RX_REF_SVH

// Galois LFSR shifting right with taps for x^32 + x^31 + x^29 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
   if (state[0])
      return (state >> 1) ^ 32'hd000_0001;
   else
      return state >> 1;
endfunction

// The row sits above the low VIDIN_COL_BITS column bits of the address
// A scale of s keeps a pixel when its row and its column are both multiples of s
function automatic strobe_t expected_strobes(input pix_addr_t addr);
   int      col;
   int      row;
   int      scale;
   strobe_t s;
   col = int'(addr[`VIDIN_COL_BITS-1:0]);
   row = int'(addr[`VIDIN_ADDR_W-1:`VIDIN_COL_BITS]);
   for (int k = 0; k < 6; k++)
   begin
      // Strobe pairs run left then right for scales 1, 2 and 4
      scale = 1 << (k / 2);
      s[k]  = ((col % scale) == 0) && ((row % scale) == 0);
   end
   return s;
endfunction

// Components sit rp, ip, rn, in from the top bits down
function automatic quad_t pack_quad(
   input bus_word_t c_rp,
   input bus_word_t c_ip,
   input bus_word_t c_rn,
   input bus_word_t c_in
);
   return {c_rp, c_ip, c_rn, c_in};
endfunction

// Bus word k rides in data bits 16k up and rp is word 0
function automatic logic [63:0] quad_bus_data(input quad_t q);
   return {q[15:0], q[31:16], q[47:32], q[63:48]};
endfunction

`endif

/* testbench/vidin_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vidin_config.svh"

module vidin_rx_tb;

   import vidin_bus_pkg::*;
   import vidin_frame_pkg::*;

   `include "vidin_rx_ref.svh"

   // A transfer takes three cycles, so 20 per write leaves plenty of room
   localparam int RESET_CYCLES = 4;
   localparam int NUM_WRITES   = 46;
   localparam int CYCLE_LIMIT  = 20 * NUM_WRITES + RESET_CYCLES;

   logic                       clk = 1'b0;
   logic                       rst = 1'b1;
   logic                       cyc;
   logic                       stb;
   logic                       we;
   logic [`VIDIN_SLOT_W-1:0]   adr;
   logic [4*`VIDIN_WORD_W-1:0] dat_w;
   logic                       ack;
   pix_addr_t                  pix_addr;
   logic                       comp_switch;
   strobe_t                    new_data;
   quad_t                      out_q [6];

   quad_t       staged [6];
   quad_t       published [6];
   pix_addr_t   exp_addr;
   logic        exp_sw;
   strobe_t     exp_new_data;
   logic        ack_prev = 1'b0;
   logic [31:0] lfsr_state;
   string       test_name;
   int          error_count = 0;
   int          check_count = 0;
   int          test_count = 0;
   int          test_first_error = 0;
   int          cycle_count;

   vidin_rx_top uut (
      .clk          (clk),
      .rst          (rst),
      .cyc          (cyc),
      .stb          (stb),
      .we           (we),
      .adr          (adr),
      .dat_w        (dat_w),
      .ack          (ack),
      .pix_addr     (pix_addr),
      .comp_switch  (comp_switch),
      .new_data     (new_data),
      .out_s1_left  (out_q[0]),
      .out_s1_right (out_q[1]),
      .out_s2_left  (out_q[2]),
      .out_s2_right (out_q[3]),
      .out_s4_left  (out_q[4]),
      .out_s4_right (out_q[5])
   );

   initial
   begin
      forever #10 clk = ~clk;
   end

   function automatic logic [63:0] random_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[62:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      check_count++;
      assert (act === exp)
      else
      begin
         $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
         error_count++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_first_error = error_count;
   endtask

   task automatic finish_test();
      test_count++;
      if (error_count == test_first_error)
         $display("test %s: ok", test_name);
      else
         $display("test %s: %0d errors", test_name, error_count - test_first_error);
   endtask

   // Called a little after a rising edge, returns one idle cycle after ack
   task automatic bus_transfer(input logic [2:0] slot, input logic [63:0] data, input logic write);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = slot;
      dat_w = data;
      @(posedge clk);
      #1;
      while (!ack)
      begin
         @(posedge clk);
         #1;
      end
      cyc = 1'b0;
      stb = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic stage_quad(input int idx);
      logic [63:0] r;
      r = random_bits(64);
      staged[idx] = pack_quad(r[63:48], r[47:32], r[31:16], r[15:0]);
      bus_transfer(3'(idx + 2), quad_bus_data(staged[idx]), 1'b1);
   endtask

   task automatic check_outputs();
      for (int i = 0; i < 6; i++)
         check_value($sformatf("out quad %0d", i), published[i], out_q[i]);
      check_value("pix_addr", 64'(exp_addr), 64'(pix_addr));
      check_value("comp_switch", 64'(exp_sw), 64'(comp_switch));
   endtask

   // Low bits of word 1 and the upper words are noise the receiver drops
   task automatic commit_frame(input pix_addr_t addr, input logic sw);
      logic [63:0] data;
      data        = random_bits(64);
      data[15:0]  = addr[15:0];
      data[31:29] = addr[18:16];
      data[28]    = sw;
      bus_transfer(3'd1, data, 1'b1);
      for (int i = 0; i < 6; i++)
         published[i] = staged[i];
      exp_addr = addr;
      exp_sw   = sw;
      check_value("new_data", 64'(expected_strobes(addr)), 64'(new_data));
      check_outputs();
   endtask

   // Checks new_data every cycle against the commit seen acked one cycle before
   always @(negedge clk)
   begin
      if (rst !== 1'b0)
      begin
         exp_new_data = '0;
         ack_prev     = 1'b0;
      end
      else
      begin
         check_value("new_data", 64'(exp_new_data), 64'(new_data));
         check_count++;
         assert (!(ack && ack_prev))
         else
         begin
            $display("%s: ack stayed high for two cycles", test_name);
            error_count++;
         end
         if (ack && we && slot_e'(adr) == slot_commit)
            exp_new_data = expected_strobes({dat_w[31:29], dat_w[15:0]});
         else
            exp_new_data = '0;
         ack_prev = ack;
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
   end

   initial
   begin
      pix_addr_t a;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat_w      = '0;
      lfsr_state = 32'ha533_2058;
      exp_addr   = '0;
      exp_sw     = 1'b0;
      for (int i = 0; i < 6; i++)
      begin
         staged[i]    = '0;
         published[i] = '0;
      end

      start_test("reset_state");
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      check_value("ack", 64'd0, 64'(ack));
      check_value("new_data", 64'd0, 64'(new_data));
      check_outputs();
      finish_test();

      start_test("full_frame");
      for (int i = 0; i < 6; i++)
         stage_quad(i);
      commit_frame(pix_addr_t'(random_bits(19)), 1'(random_bits(1)));
      finish_test();

      start_test("strobe_sweep");
      for (int i = 0; i < 32; i++)
         commit_frame(pix_addr_t'(random_bits(19)), 1'(random_bits(1)));
      // Bits 0 and 9 clear with bit 1 set gives scale 2 without scale 4
      a = (pix_addr_t'(random_bits(19)) & ~19'h00201) | 19'h00002;
      commit_frame(a, 1'b0);
      a = pix_addr_t'(random_bits(19)) & ~19'h00603;
      commit_frame(a, 1'b1);
      finish_test();

      start_test("partial_restage");
      stage_quad(2);
      commit_frame(pix_addr_t'(random_bits(19)), 1'(random_bits(1)));
      finish_test();

      start_test("ignored_traffic");
      bus_transfer(3'd0, random_bits(64), 1'b1);
      bus_transfer(3'd3, random_bits(64), 1'b0);
      check_value("new_data", 64'd0, 64'(new_data));
      check_outputs();
      // A commit shows whether the read left the slot 3 quad staged as before
      commit_frame(pix_addr_t'(random_bits(19)), 1'(random_bits(1)));
      finish_test();

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
+incdir+testbench
logic/vidin_bus_pkg.sv
logic/vidin_frame_pkg.sv
logic/vidin_wb_port.sv
logic/vidin_frame_stage.sv
logic/vidin_frame_publish.sv
logic/vidin_rx_top.sv
testbench/vidin_rx_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := vidin_rx_tb
RTL_TOP   := vidin_rx_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

# The design alone first, then the testbench around it
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(BIN) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
